/* src/scaler_pkg.sv */
// scaler package: shared widths, stream structs and controller states
`default_nettype none

package scaler_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int PIX_W  = 8;                // grey pixel
	localparam int DIM_W  = 12;               // line dimensions
	localparam int FRAC_W = 8;                // position fraction
	localparam int POS_W  = DIM_W + FRAC_W;   // 12.8 accumulator
	localparam int STEP_W = 16;               // k_step in 8.8

	// ----------------------------------------
	// stream and job types
	// ----------------------------------------
	typedef logic [PIX_W-1:0] pix_t;

	// line configuration, sampled with the first pixel
	typedef struct packed {
		logic [DIM_W-1:0]  s_width;
		logic [DIM_W-1:0]  t_width;
		logic [STEP_W-1:0] k_step;   // 256 is unity
	} cfg_t;

	typedef struct packed {
		logic [FRAC_W-1:0] frac;     // weight of the right pixel
		logic              last;     // final output pixel of the line
	} tap_t;

	typedef struct packed {
		pix_t data;
		logic last;
	} pix_out_t;

	typedef enum logic {
		ST_LOAD,
		ST_EMIT
	} ctrl_state_t;

endpackage

`default_nettype wire

/* src/line_buffer.sv */
// line buffer: one stored line, one write port and two registered read-first read ports
`default_nettype none

module line_buffer #(
	parameter int MAX_WIDTH = 2048,
	localparam int AW = $clog2(MAX_WIDTH)
) (
	input  wire                   sys_clk,
	input  wire                   wr_en,
	input  wire [AW-1:0]          wr_addr,
	input  wire scaler_pkg::pix_t wr_data,
	input  wire [AW-1:0]          rd_addr_a,
	input  wire [AW-1:0]          rd_addr_b,
	output scaler_pkg::pix_t      rd_data_a,
	output scaler_pkg::pix_t      rd_data_b
);

	scaler_pkg::pix_t mem [MAX_WIDTH];

	// both reads see the old word when the same address is written
	always_ff @(posedge sys_clk) begin
		rd_data_a <= mem[rd_addr_a];    // left tap
		rd_data_b <= mem[rd_addr_b];    // right tap
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// a line longer than the buffer would wrap onto its own start
	wr_addr_range_a: assert property (@(posedge sys_clk)
		wr_en |-> (int'(wr_addr) < MAX_WIDTH));

endmodule

`default_nettype wire

/* src/coord_gen.sv */
// coordinate generator: loads a line, then steps the 8.8 position and issues blend jobs
`default_nettype none

module coord_gen #(
	parameter int MAX_WIDTH = 2048,
	localparam int AW = $clog2(MAX_WIDTH)
) (
	input  wire                   sys_clk,
	input  wire                   rst_n,
	// pixel stream in
	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire scaler_pkg::pix_t in_pixel,
	input  wire scaler_pkg::cfg_t cfg,
	// line buffer write
	output logic                  wr_en,
	output logic [AW-1:0]         wr_addr,
	output scaler_pkg::pix_t      wr_data,
	// line buffer read and job issue
	output logic [AW-1:0]         rd_addr_a,
	output logic [AW-1:0]         rd_addr_b,
	output logic                  issue,
	output scaler_pkg::tap_t      tap,
	input  wire                   almost_full
);

	scaler_pkg::ctrl_state_t      state;
	scaler_pkg::cfg_t             cfg_q;        // config of the current line
	logic [scaler_pkg::DIM_W-1:0] load_cnt;     // pixels taken so far
	logic [scaler_pkg::DIM_W-1:0] emit_cnt;     // jobs issued so far
	logic [scaler_pkg::POS_W-1:0] pos;          // 12.8 source position

	logic                         in_fire;
	logic                         first_pix;
	logic [scaler_pkg::DIM_W-1:0] line_s_width;
	logic                         load_done;
	logic [scaler_pkg::POS_W-1:0] step_ext;
	logic [scaler_pkg::DIM_W-1:0] s_max;
	logic [scaler_pkg::DIM_W-1:0] pos_int;
	logic [scaler_pkg::DIM_W-1:0] idx_a;
	logic [scaler_pkg::DIM_W-1:0] idx_b;
	logic                         emit_last;

	// ----------------------------------------
	// load side
	// ----------------------------------------
	assign in_ready  = (state == scaler_pkg::ST_LOAD);
	assign in_fire   = in_valid && in_ready;
	assign first_pix = (load_cnt == '0);

	// the first pixel has no latched width yet
	assign line_s_width = first_pix ? cfg.s_width : cfg_q.s_width;
	assign load_done    = in_fire && (load_cnt == line_s_width - 1'b1);

	assign wr_en   = in_fire;               // written on the transfer edge
	assign wr_addr = load_cnt[AW-1:0];
	assign wr_data = in_pixel;

	// ----------------------------------------
	// emit side
	// ----------------------------------------
	assign step_ext = {{(scaler_pkg::POS_W - scaler_pkg::STEP_W){1'b0}}, cfg_q.k_step};
	assign s_max    = cfg_q.s_width - 1'b1;
	assign pos_int  = pos[scaler_pkg::POS_W-1:scaler_pkg::FRAC_W];

	// clamp both taps to the last stored pixel
	assign idx_a = (pos_int > s_max) ? s_max : pos_int;
	assign idx_b = (idx_a >= s_max) ? s_max : idx_a + 1'b1;

	assign rd_addr_a = idx_a[AW-1:0];
	assign rd_addr_b = idx_b[AW-1:0];

	assign emit_last = (emit_cnt == cfg_q.t_width - 1'b1);
	assign issue     = (state == scaler_pkg::ST_EMIT) && !almost_full;   // throttle
	assign tap       = '{frac: pos[scaler_pkg::FRAC_W-1:0], last: emit_last};

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= scaler_pkg::ST_LOAD;
			load_cnt <= '0;
			emit_cnt <= '0;
			pos      <= '0;
		end else begin
			case (state)
				scaler_pkg::ST_LOAD: begin
					if (load_done) begin
						state    <= scaler_pkg::ST_EMIT;
						load_cnt <= '0;
						emit_cnt <= '0;
						pos      <= '0;     // output 0 sits on source 0
					end else if (in_fire) begin
						load_cnt <= load_cnt + 1'b1;
					end
				end
				scaler_pkg::ST_EMIT: begin
					if (issue) begin
						pos      <= pos + step_ext;
						emit_cnt <= emit_cnt + 1'b1;
						if (emit_last) begin
							state <= scaler_pkg::ST_LOAD;
						end
					end
				end
				default: begin
					state <= scaler_pkg::ST_LOAD;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (in_fire && first_pix) begin
			cfg_q <= cfg;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	cfg_nonzero_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(state == scaler_pkg::ST_EMIT) |-> (cfg_q.s_width != '0) && (cfg_q.t_width != '0));

	// wr_addr keeps only the low counter bits, so a long line would wrap
	load_range_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		in_fire |-> (int'(load_cnt) < MAX_WIDTH));

endmodule

`default_nettype wire

/* src/blend_pipe.sv */
// blend pipeline: weights two neighbouring pixels by the position fraction in two stages
`default_nettype none

module blend_pipe (
	input  wire                   sys_clk,
	input  wire                   rst_n,
	input  wire                   issue,
	input  wire scaler_pkg::tap_t tap,
	input  wire scaler_pkg::pix_t rd_data_a,
	input  wire scaler_pkg::pix_t rd_data_b,
	output logic                  res_valid,
	output scaler_pkg::pix_out_t  res_word
);

	localparam int PROD_W = scaler_pkg::PIX_W + scaler_pkg::FRAC_W + 1;   // 8x9 product

	logic                          iss_d;       // aligned with read data
	scaler_pkg::tap_t              tap_d;
	logic [scaler_pkg::FRAC_W:0]   w_a;
	logic [scaler_pkg::FRAC_W:0]   w_b;
	logic                          s1_valid;
	logic                          s1_last;
	logic [PROD_W-1:0]             prod_a;
	logic [PROD_W-1:0]             prod_b;
	logic [PROD_W-1:0]             sum;

	// weights always add up to 256
	assign w_b = {1'b0, tap_d.frac};
	assign w_a = {1'b1, {scaler_pkg::FRAC_W{1'b0}}} - w_b;

	assign sum = prod_a + prod_b;   // at most 255*256, no carry out

	// ----------------------------------------
	// valid bits
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			iss_d     <= 1'b0;
			s1_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			iss_d     <= issue;
			s1_valid  <= iss_d;
			res_valid <= s1_valid;
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		tap_d    <= tap;
		// stage one
		prod_a   <= rd_data_a * w_a;
		prod_b   <= rd_data_b * w_b;
		s1_last  <= tap_d.last;
		// stage two, drop the fraction bits
		res_word <= '{data: sum[scaler_pkg::FRAC_W +: scaler_pkg::PIX_W], last: s1_last};
	end

endmodule

`default_nettype wire

/* src/out_fifo.sv */
// output fifo: buffers blended words behind a valid/ready port and throttles job issue
`default_nettype none

module out_fifo #(
	parameter int FIFO_DEPTH = 8,
	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
	localparam int CW = $clog2(FIFO_DEPTH + 1)
) (
	input  wire                       sys_clk,
	input  wire                       rst_n,
	input  wire                       wr_valid,
	input  wire scaler_pkg::pix_out_t wr_word,
	output logic                      almost_full,
	output logic                      out_valid,
	input  wire                       out_ready,
	output scaler_pkg::pix_out_t      out_word
);

	localparam int IN_FLIGHT = 3;   // jobs between issue and write

	scaler_pkg::pix_out_t mem [FIFO_DEPTH];
	logic [PW-1:0]        wr_ptr;
	logic [PW-1:0]        rd_ptr;
	logic [CW-1:0]        count;
	logic                 rd_fire;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		if (p == PW'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign out_valid   = (count != '0);
	assign out_word    = mem[rd_ptr];        // steady until popped
	assign rd_fire     = out_valid && out_ready;
	assign almost_full = (CW'(FIFO_DEPTH) - count) <= CW'(IN_FLIGHT);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_fire) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({wr_valid, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // none or both
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_valid) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// the pipe has no stall, so issue throttling must keep a slot free
	no_write_full_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		wr_valid |-> (count < CW'(FIFO_DEPTH)));

endmodule

`default_nettype wire

/* src/hscaler_top.sv */
// horizontal bilinear scaler top: line load, coordinate issue, blend and output fifo
`default_nettype none

module hscaler_top #(
	parameter int MAX_WIDTH  = 2048,
	parameter int FIFO_DEPTH = 8
) (
	input  wire                   sys_clk,
	input  wire                   rst_n,
	// pixel stream in
	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire scaler_pkg::pix_t in_pixel,
	input  wire scaler_pkg::cfg_t cfg,
	// scaled stream out
	output logic                  out_valid,
	input  wire                   out_ready,
	output scaler_pkg::pix_out_t  out_word
);

	localparam int AW = $clog2(MAX_WIDTH);

	// line buffer write
	logic                 wr_en;
	logic [AW-1:0]        wr_addr;
	scaler_pkg::pix_t     wr_data;
	// line buffer read
	logic [AW-1:0]        rd_addr_a;
	logic [AW-1:0]        rd_addr_b;
	scaler_pkg::pix_t     rd_data_a;
	scaler_pkg::pix_t     rd_data_b;
	// job and result
	logic                 issue;
	scaler_pkg::tap_t     tap;
	logic                 res_valid;
	scaler_pkg::pix_out_t res_word;
	logic                 almost_full;

	coord_gen #(.MAX_WIDTH(MAX_WIDTH)) u_coord_gen (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_pixel    (in_pixel),
		.cfg         (cfg),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.issue       (issue),
		.tap         (tap),
		.almost_full (almost_full)
	);

	line_buffer #(.MAX_WIDTH(MAX_WIDTH)) u_line_buffer (
		.sys_clk   (sys_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	blend_pipe u_blend_pipe (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.tap       (tap),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.res_valid (res_valid),
		.res_word  (res_word)
	);

	out_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.wr_valid    (res_valid),
		.wr_word     (res_word),
		.almost_full (almost_full),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_word    (out_word)
	);

endmodule

`default_nettype wire

/* verification/tb_tests.svh */
// scaler directed tests: line send, word collection and the individual test cases
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ----------------------------------------
// helpers
// ----------------------------------------
task automatic give_up(input string what);
	$display("timeout: %s", what);
	error_count++;
	aborted = 1'b1;
endtask

task automatic fill_random(output scaler_pkg::pix_t src[$], input int n);
	src = {};
	for (int i = 0; i < n; i++) begin
		src.push_back(scaler_pkg::pix_t'($random(seed)));
	end
endtask

task automatic send_line(input string name, input scaler_pkg::pix_t src[$],
		input scaler_pkg::cfg_t c);
	int waited;
	cfg = c;    // held through the first transfer
	foreach (src[i]) begin
		in_valid = 1'b1;
		in_pixel = src[i];
		waited   = 0;
		while (!in_ready && !aborted) begin
			waited++;
			if (waited > WAIT_MAX) give_up($sformatf("%s never saw in_ready for pixel %0d", name, i));
			@(posedge sys_clk);
			#1;
		end
		if (aborted) break;
		@(posedge sys_clk);     // transfer edge
		#1;
	end
	in_valid = 1'b0;
endtask

// in_ready must stay low until the final job has issued
task automatic check_busy(input string name, input int min_cycles);
	int low;
	low = 0;
	while (!in_ready && !aborted) begin
		low++;
		if (low > WAIT_MAX) give_up($sformatf("%s in_ready stuck low", name));
		@(posedge sys_clk);
		#1;
	end
	assert (low >= min_cycles) else begin
		$display("** Error: %s in_ready low cycles expected >= %0d actual %0d",
			name, min_cycles, low);
		error_count++;
	end
endtask

task automatic collect_words(input string name, input int n, input bit random_ready);
	int               got;
	int               idle;
	scaler_pkg::pix_t e_data;
	bit               e_last;
	got  = 0;
	idle = 0;
	while (got < n && !aborted) begin
		out_ready = random_ready ? 1'($random(seed)) : 1'b1;
		if (out_valid && out_ready) begin
			e_data = exp_data.pop_front();
			e_last = exp_last.pop_front();
			assert (out_word.data == e_data) else begin
				$display("** Error: %s word %0d data expected %0d actual %0d",
					name, got, e_data, out_word.data);
				error_count++;
			end
			assert (out_word.last == e_last) else begin
				$display("** Error: %s word %0d last expected %0d actual %0d",
					name, got, e_last, out_word.last);
				error_count++;
			end
			got++;
			idle = 0;
		end else begin
			idle++;
			if (idle > WAIT_MAX) give_up($sformatf("%s stalled after %0d words", name, got));
		end
		@(posedge sys_clk);
		#1;
	end
	out_ready = 1'b0;
endtask

// nothing may follow the last word of a line
task automatic check_idle(input string name);
	out_ready = 1'b1;
	repeat (8) begin
		assert (!out_valid) else begin
			$display("** Error: %s extra word expected none actual %0d", name, out_word.data);
			error_count++;
		end
		@(posedge sys_clk);
		#1;
	end
	out_ready = 1'b0;
endtask

task automatic run_line(input string name, input scaler_pkg::cfg_t c, input bit random_ready);
	scaler_pkg::pix_t src[$];
	fill_random(src, int'(c.s_width));
	model_line(src, c);
	send_line(name, src, c);
	collect_words(name, int'(c.t_width), random_ready);
	check_idle(name);
endtask

// ----------------------------------------
// test cases
// ----------------------------------------
task automatic identity_check();
	run_line("identity", '{s_width: 12'd16, t_width: 12'd16, k_step: 16'd256}, 1'b0);
endtask

task automatic halve_width();
	run_line("downscale", '{s_width: 12'd16, t_width: 12'd8, k_step: 16'd512}, 1'b0);
endtask

task automatic double_width();
	run_line("upscale", '{s_width: 12'd16, t_width: 12'd32, k_step: 16'd128}, 1'b0);
endtask

task automatic random_backpressure();
	run_line("backpressure", '{s_width: 12'd16, t_width: 12'd16, k_step: 16'd341}, 1'b1);
endtask

task automatic back_to_back_lines();
	scaler_pkg::cfg_t c1;
	scaler_pkg::cfg_t c2;
	scaler_pkg::pix_t src1[$];
	scaler_pkg::pix_t src2[$];
	c1 = '{s_width: 12'd20, t_width: 12'd10, k_step: 16'd512};
	c2 = '{s_width: 12'd12, t_width: 12'd24, k_step: 16'd120};
	fill_random(src1, 20);
	fill_random(src2, 12);
	model_line(src1, c1);
	model_line(src2, c2);
	fork
		begin
			send_line("back_to_back", src1, c1);
			check_busy("back_to_back", 10);
			send_line("back_to_back", src2, c2);
			check_busy("back_to_back", 24);
		end
		collect_words("back_to_back", 34, 1'b0);
	join
	check_idle("back_to_back");
endtask

`endif

/* verification/tb_hscaler.sv */
// horizontal scaler testbench: clock, reset, DUT, reference model and test sequence
`default_nettype none

module tb_hscaler;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_MAX = 500;      // cycles allowed per wait loop

	logic                 sys_clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_ready;
	scaler_pkg::pix_t     in_pixel;
	scaler_pkg::cfg_t     cfg;
	logic                 out_valid;
	logic                 out_ready;
	scaler_pkg::pix_out_t out_word;

	int               error_count = 0;
	bit               aborted = 1'b0;   // set once a wait times out
	int               seed = 97;
	scaler_pkg::pix_t exp_data[$];      // expected words, oldest first
	bit               exp_last[$];

	hscaler_top #(
		.MAX_WIDTH  (2048),
		.FIFO_DEPTH (8)
	) u_hscaler_top (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pixel  (in_pixel),
		.cfg       (cfg),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_word  (out_word)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;    // 8 ns period
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// bilinear rule, one line appended to the expected queues
	task automatic model_line(input scaler_pkg::pix_t src[$], input scaler_pkg::cfg_t c);
		int pos;
		int ia;
		int ib;
		int f;
		int s_last;
		s_last = int'(c.s_width) - 1;
		for (int j = 0; j < int'(c.t_width); j++) begin
			pos = j * int'(c.k_step);
			f   = pos % 256;
			ia  = (pos / 256 > s_last) ? s_last : pos / 256;    // left tap clamp
			ib  = (ia + 1 > s_last) ? s_last : ia + 1;
			exp_data.push_back(scaler_pkg::pix_t'((src[ia] * (256 - f) + src[ib] * f) / 256));
			exp_last.push_back(j == int'(c.t_width) - 1);
		end
	endtask

	`include "tb_tests.svh"

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_pixel  = '0;
		cfg       = '0;
		out_ready = 1'b0;
		repeat (10) @(posedge sys_clk);
		#1 rst_n = 1'b1;
		@(posedge sys_clk);
		#1;
		assert (in_ready && !out_valid) else begin
			$display("** Error: reset in_ready/out_valid expected 1/0 actual %0d/%0d",
				in_ready, out_valid);
			error_count++;
		end
		identity_check();
		if (!aborted) halve_width();
		if (!aborted) double_width();
		if (!aborted) random_backpressure();
		if (!aborted) back_to_back_lines();
		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+verification
src/scaler_pkg.sv
src/line_buffer.sv
src/coord_gen.sv
src/blend_pipe.sv
src/out_fifo.sv
src/hscaler_top.sv
verification/tb_hscaler.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_hscaler
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
